// File: source/csr_pkg.sv
package csr_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int CNT_WIDTH = 2 * XLEN;   // mcycle and minstret

    ////////////////////////////////////////
    // CSR addresses
    ////////////////////////////////////////

    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,   // User read-only aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,   // ID registers, all read as zero
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_t;

    // Same encoding as funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    ////////////////////////////////////////
    // Write masks and constants
    ////////////////////////////////////////

    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h007E19AA;
    localparam logic [XLEN-1:0] MISA_WMASK    = 32'h00301000;
    localparam logic [XLEN-1:0] MIE_WMASK     = 32'h00000888;  // MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] ALIGN_WMASK   = 32'hFFFFFFFC;  // mtvec and mepc
    localparam logic [XLEN-1:0] FULL_WMASK    = '1;

    // RV32 base, I and M extensions, user mode
    localparam logic [XLEN-1:0] MISA_VALUE    = 32'h40101100;

    typedef struct packed {
        logic            read;
        logic            write;
        csr_op_e         op;
        csr_addr_t       addr;
        logic [XLEN-1:0] data;
        logic            killed;   // Set when the instruction was flushed
    } csr_req_t;

endpackage

// File: source/trap_pkg.sv
package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Synchronous exception causes
    typedef enum logic [4:0] {
        INSTRUCTION_MISALIGNED = 5'd0,
        INSTRUCTION_FAULT      = 5'd1,
        ILLEGAL_INSTRUCTION    = 5'd2,
        BREAKPOINT             = 5'd3,
        LOAD_MISALIGNED        = 5'd4,
        LOAD_FAULT             = 5'd5,
        STORE_MISALIGNED       = 5'd6,
        STORE_FAULT            = 5'd7,
        ECALL_U                = 5'd8,
        ECALL_M                = 5'd11
    } exc_code_e;

    // Interrupt causes, also the bit index in mip and mie
    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    ////////////////////////////////////////
    // mstatus fields
    ////////////////////////////////////////

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;   // Two bits wide

    typedef struct packed {
        logic                     raise_exception;
        logic                     machine_return;
        logic                     interrupt_ack;
        exc_code_e                exception_code;
        logic [csr_pkg::XLEN-1:0] pc;
        logic [csr_pkg::XLEN-1:0] instruction;
        logic                     jump;          // Trap lands on a taken jump
        logic [csr_pkg::XLEN-1:0] jump_target;
    } trap_req_t;

endpackage

// File: source/csr_access.sv
`timescale 1ns/1ps

module csr_access
    import csr_pkg::*;
(
    input  csr_req_t          csr_req_i,
    input  logic [XLEN-1:0]   mstatus_i,
    input  logic [XLEN-1:0]   misa_i,
    input  logic [XLEN-1:0]   mie_i,
    input  logic [XLEN-1:0]   mip_i,
    input  logic [XLEN-1:0]   mtvec_i,
    input  logic [XLEN-1:0]   mscratch_i,
    input  logic [XLEN-1:0]   mepc_i,
    input  logic [XLEN-1:0]   mcause_i,
    input  logic [XLEN-1:0]   mtval_i,
    input  logic [CNT_WIDTH-1:0] mcycle_i,
    input  logic [CNT_WIDTH-1:0] minstret_i,
    output logic              wr_en_o,
    output csr_addr_t         wr_addr_o,
    output logic [XLEN-1:0]   wr_data_o,
    output logic [XLEN-1:0]   rdata_o
);

    logic            read_ok;
    logic            write_ok;
    logic [XLEN-1:0] cur_val;
    logic [XLEN-1:0] wmask;
    logic [XLEN-1:0] masked_data;

    assign read_ok  = csr_req_i.read  & ~csr_req_i.killed;
    assign write_ok = csr_req_i.write & ~csr_req_i.killed;

    ////////////////////////////////////////
    // Current value and mask
    ////////////////////////////////////////

    always_comb begin
        case (csr_req_i.addr)
            MSTATUS:   cur_val = mstatus_i;
            MISA:      cur_val = misa_i;
            MIE:       cur_val = mie_i;
            MTVEC:     cur_val = mtvec_i;
            MSCRATCH:  cur_val = mscratch_i;
            MEPC:      cur_val = mepc_i;
            MCAUSE:    cur_val = mcause_i;
            MTVAL:     cur_val = mtval_i;
            MCYCLE:    cur_val = mcycle_i[XLEN-1:0];
            MCYCLEH:   cur_val = mcycle_i[CNT_WIDTH-1:XLEN];
            MINSTRET:  cur_val = minstret_i[XLEN-1:0];
            MINSTRETH: cur_val = minstret_i[CNT_WIDTH-1:XLEN];
            default:   cur_val = '0;
        endcase
    end

    // Unknown and read-only addresses take no write
    always_comb begin
        case (csr_req_i.addr)
            MSTATUS:     wmask = MSTATUS_WMASK;
            MISA:        wmask = MISA_WMASK;
            MIE:         wmask = MIE_WMASK;
            MTVEC, MEPC: wmask = ALIGN_WMASK;
            MSCRATCH, MCAUSE, MTVAL,
            MCYCLE, MCYCLEH,
            MINSTRET, MINSTRETH: wmask = FULL_WMASK;
            default:     wmask = '0;
        endcase
    end

    // Set and clear only touch writable bits
    assign masked_data = csr_req_i.data & wmask;

    always_comb begin
        case (csr_req_i.op)
            CSR_SET:   wr_data_o = cur_val | masked_data;
            CSR_CLEAR: wr_data_o = cur_val & ~masked_data;
            default:   wr_data_o = (cur_val & ~wmask) | masked_data;
        endcase
    end

    assign wr_en_o   = write_ok;
    assign wr_addr_o = csr_req_i.addr;

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        rdata_o = '0;
        if (read_ok) begin
            case (csr_req_i.addr)
                MSTATUS:            rdata_o = mstatus_i;
                MISA:               rdata_o = misa_i;
                MIE:                rdata_o = mie_i;
                MIP:                rdata_o = mip_i;
                MTVEC:              rdata_o = mtvec_i;
                MSCRATCH:           rdata_o = mscratch_i;
                MEPC:               rdata_o = mepc_i;
                MCAUSE:             rdata_o = mcause_i;
                MTVAL:              rdata_o = mtval_i;
                MCYCLE, CYCLE:      rdata_o = mcycle_i[XLEN-1:0];
                MCYCLEH, CYCLEH:    rdata_o = mcycle_i[CNT_WIDTH-1:XLEN];
                MINSTRET, INSTRET:  rdata_o = minstret_i[XLEN-1:0];
                MINSTRETH, INSTRETH: rdata_o = minstret_i[CNT_WIDTH-1:XLEN];
                default:            rdata_o = '0;   // ID registers and unknown
            endcase
        end
    end

endmodule

// File: source/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  trap_req_t       trap_req_i,
    input  logic            wr_en_i,
    input  csr_addr_t       wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i,
    input  irq_code_e       irq_code_i,
    output logic [XLEN-1:0] mstatus_o,
    output logic [XLEN-1:0] misa_o,
    output logic [XLEN-1:0] mie_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mscratch_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mcause_o,
    output logic [XLEN-1:0] mtval_o,
    output priv_e           privilege_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] misa_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;
    priv_e           privilege_q;

    logic [1:0]      mpp;
    priv_e           ret_priv;

    assign mpp = mstatus_q[MPP_LSB +: 2];

    // Only user and machine exist, anything else returns to machine
    assign ret_priv = (mpp == PRIV_USER) ? PRIV_USER : PRIV_MACHINE;

    ////////////////////////////////////////
    // Trap and write sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_q   <= '0;
            misa_q      <= MISA_VALUE;
            mie_q       <= '0;
            mtvec_q     <= '0;
            mscratch_q  <= '0;
            mepc_q      <= '0;
            mcause_q    <= '0;
            mtval_q     <= '0;
            privilege_q <= PRIV_MACHINE;
        end
        else if (trap_req_i.machine_return) begin
            mstatus_q[MIE_BIT] <= mstatus_q[MPIE_BIT];
            privilege_q        <= ret_priv;
        end
        else if (trap_req_i.raise_exception) begin
            mcause_q                <= {1'b0, {(XLEN-6){1'b0}}, trap_req_i.exception_code};
            mepc_q                  <= trap_req_i.pc;
            mtval_q                 <= (trap_req_i.exception_code == ILLEGAL_INSTRUCTION)
                                       ? trap_req_i.instruction
                                       : trap_req_i.pc;
            mstatus_q[MPP_LSB +: 2] <= privilege_q;
            mstatus_q[MPIE_BIT]     <= mstatus_q[MIE_BIT];
            mstatus_q[MIE_BIT]      <= 1'b0;
            privilege_q             <= PRIV_MACHINE;
        end
        else if (trap_req_i.interrupt_ack) begin
            mcause_q                <= {1'b1, {(XLEN-6){1'b0}}, irq_code_i};
            mstatus_q[MPP_LSB +: 2] <= privilege_q;
            mstatus_q[MPIE_BIT]     <= mstatus_q[MIE_BIT];
            mstatus_q[MIE_BIT]      <= 1'b0;
            privilege_q             <= PRIV_MACHINE;
            // Current instruction retires first, resume at the next one
            if (trap_req_i.jump) begin
                mepc_q <= trap_req_i.jump_target;
            end
            else begin
                mepc_q <= trap_req_i.pc + 32'd4;
            end
        end
        else if (wr_en_i) begin
            case (wr_addr_i)
                MSTATUS:  mstatus_q  <= wr_data_i;
                MISA:     misa_q     <= wr_data_i;
                MIE:      mie_q      <= wr_data_i;
                MTVEC:    mtvec_q    <= wr_data_i;
                MSCRATCH: mscratch_q <= wr_data_i;
                MEPC:     mepc_q     <= wr_data_i;
                MCAUSE:   mcause_q   <= wr_data_i;
                MTVAL:    mtval_q    <= wr_data_i;
                default:  ;           // Counters and read-only
            endcase
        end
    end

    assign mstatus_o   = mstatus_q;
    assign misa_o      = misa_q;
    assign mie_o       = mie_q;
    assign mtvec_o     = mtvec_q;
    assign mscratch_o  = mscratch_q;
    assign mepc_o      = mepc_q;
    assign mcause_o    = mcause_q;
    assign mtval_o     = mtval_q;
    assign privilege_o = privilege_q;

endmodule

// File: source/csr_counters.sv
`timescale 1ns/1ps

module csr_counters
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 killed_i,
    input  logic                 wr_en_i,
    input  csr_addr_t            wr_addr_i,
    input  logic [XLEN-1:0]      wr_data_i,
    output logic [CNT_WIDTH-1:0] mcycle_o,
    output logic [CNT_WIDTH-1:0] minstret_o
);

    logic [CNT_WIDTH-1:0] mcycle_q;
    logic [CNT_WIDTH-1:0] minstret_q;

    // A half write replaces the increment for that cycle
    function automatic logic [CNT_WIDTH-1:0] next_count(
        input logic [CNT_WIDTH-1:0] cur,
        input logic                 inc,
        input logic                 wr_lo,
        input logic                 wr_hi,
        input logic [XLEN-1:0]      data
    );
        logic [CNT_WIDTH-1:0] nxt;
        nxt = cur + {{(CNT_WIDTH-1){1'b0}}, inc};
        if (wr_lo) begin
            nxt = {cur[CNT_WIDTH-1:XLEN], data};
        end
        else if (wr_hi) begin
            nxt = {data, cur[XLEN-1:0]};
        end
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end
        else begin
            mcycle_q   <= next_count(mcycle_q, 1'b1, wr_en_i && wr_addr_i == MCYCLE,
                                     wr_en_i && wr_addr_i == MCYCLEH, wr_data_i);
            minstret_q <= next_count(minstret_q, ~killed_i, wr_en_i && wr_addr_i == MINSTRET,
                                     wr_en_i && wr_addr_i == MINSTRETH, wr_data_i);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

// File: source/irq_control.sv
`timescale 1ns/1ps

module irq_control
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  logic [XLEN-1:0] irq_i,
    input  logic [XLEN-1:0] mie_i,
    input  logic            global_ie_i,       // mstatus.MIE
    input  logic            interrupt_ack_i,
    output logic [XLEN-1:0] mip_o,
    output logic            interrupt_pending_o,
    output irq_code_e       irq_code_o
);

    logic [XLEN-1:0] mip_q;
    logic [XLEN-1:0] enabled;
    logic            pending_q;
    irq_code_e       code_q;

    assign enabled = mie_i & mip_q;

    // Line sampling
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q <= '0;
        end
        else begin
            mip_q <= irq_i;
        end
    end

    ////////////////////////////////////////
    // Pending flag and cause select
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending_q <= 1'b0;
            code_q    <= M_EXT_INT;
        end
        else if (global_ie_i && (|enabled) && !interrupt_ack_i) begin
            pending_q <= 1'b1;
            if (enabled[M_EXT_INT]) begin        // External first
                code_q <= M_EXT_INT;
            end
            else if (enabled[M_SW_INT]) begin
                code_q <= M_SW_INT;
            end
            else if (enabled[M_TIM_INT]) begin
                code_q <= M_TIM_INT;
            end
        end
        else begin
            pending_q <= 1'b0;                   // Code keeps last value
        end
    end

    assign mip_o               = mip_q;
    assign interrupt_pending_o = pending_q;
    assign irq_code_o          = code_q;

endmodule

// File: source/csr_bank.sv
`timescale 1ns/1ps

module csr_bank
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,
    input  csr_req_t        csr_req_i,
    input  trap_req_t       trap_req_i,
    input  logic [XLEN-1:0] irq_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            interrupt_pending_o,
    output priv_e           privilege_o,
    output logic [XLEN-1:0] mepc_o,
    output logic [XLEN-1:0] mtvec_o
);

    logic [XLEN-1:0]      mstatus;
    logic [XLEN-1:0]      misa;
    logic [XLEN-1:0]      mie;
    logic [XLEN-1:0]      mip;
    logic [XLEN-1:0]      mscratch;
    logic [XLEN-1:0]      mcause;
    logic [XLEN-1:0]      mtval;
    logic [CNT_WIDTH-1:0] mcycle;
    logic [CNT_WIDTH-1:0] minstret;

    logic                 wr_en;
    csr_addr_t            wr_addr;
    logic [XLEN-1:0]      wr_data;
    irq_code_e            irq_code;

    ////////////////////////////////////////
    // Access decode and read mux
    ////////////////////////////////////////

    csr_access i_csr_access (
        .csr_req_i  (csr_req_i),
        .mstatus_i  (mstatus),
        .misa_i     (misa),
        .mie_i      (mie),
        .mip_i      (mip),
        .mtvec_i    (mtvec_o),
        .mscratch_i (mscratch),
        .mepc_i     (mepc_o),
        .mcause_i   (mcause),
        .mtval_i    (mtval),
        .mcycle_i   (mcycle),
        .minstret_i (minstret),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .rdata_o    (rdata_o)
    );

    csr_machine_regs i_csr_machine_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .trap_req_i  (trap_req_i),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .irq_code_i  (irq_code),
        .mstatus_o   (mstatus),
        .misa_o      (misa),
        .mie_o       (mie),
        .mtvec_o     (mtvec_o),
        .mscratch_o  (mscratch),
        .mepc_o      (mepc_o),
        .mcause_o    (mcause),
        .mtval_o     (mtval),
        .privilege_o (privilege_o)
    );

    // Counter writes still land when a trap is taken
    csr_counters i_csr_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .killed_i   (csr_req_i.killed),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    irq_control i_irq_control (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .global_ie_i         (mstatus[MIE_BIT]),
        .interrupt_ack_i     (trap_req_i.interrupt_ack),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

endmodule

// File: tb/csr_bank_properties.sv
`timescale 1ns/1ps

module csr_bank_properties
    import csr_pkg::*;
    import trap_pkg::*;
(
    input logic            clk,
    input logic            reset_n,
    input csr_req_t        csr_req_i,
    input trap_req_t       trap_req_i,
    input logic [XLEN-1:0] rdata_i,
    input logic            pending_i,
    input priv_e           privilege_i
);

    ////////////////////////////////////////
    // Reset and trap behavior
    ////////////////////////////////////////

    // One edge after reset is seen low
    reset_state: assert property (
        @(posedge clk) !reset_n |=> (privilege_i == PRIV_MACHINE) && !pending_i
    ) else $error("Privilege or pending flag wrong after reset");

    exception_priv: assert property (
        @(posedge clk) disable iff (!reset_n)
        trap_req_i.raise_exception && !trap_req_i.machine_return
            |=> privilege_i == PRIV_MACHINE
    ) else $error("Exception did not switch to machine mode");

    // Read port is quiet without a read
    idle_read_zero: assert property (
        @(posedge clk) disable iff (!reset_n)
        !csr_req_i.read |-> rdata_i == '0
    ) else $error("Read data not zero without a read request");

endmodule

// File: tb/csr_bank_tb.sv
`timescale 1ns/1ps

module csr_bank_tb
    import csr_pkg::*;
    import trap_pkg::*;
();

    typedef enum logic [2:0] {ACT_CSR, ACT_TRAP, ACT_IRQ, ACT_IDLE, ACT_WAIT} action_e;
    typedef enum logic [2:0] {CHK_NONE, CHK_RDATA, CHK_MEPC, CHK_MTVEC, CHK_PRIV, CHK_PEND} target_e;

    typedef struct packed {
        action_e         act;
        csr_req_t        req;
        trap_req_t       trap;
        logic [XLEN-1:0] irq;
        int              cycles;     // Idle length or wait timeout
        target_e         target;
        logic [XLEN-1:0] expected;
    } step_t;

    logic            clk;
    logic            reset_n;
    csr_req_t        csr_req;
    trap_req_t       trap_req;
    logic [XLEN-1:0] irq;
    logic [XLEN-1:0] rdata;
    logic            pending;
    priv_e           privilege;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtvec;

    step_t           steps[$];
    string           names[$];
    logic [XLEN-1:0] irq_level;     // Held between steps
    int              passed;
    int              failed;
    integer          seed;

    csr_bank i_csr_bank (
        .clk                 (clk),
        .reset_n             (reset_n),
        .csr_req_i           (csr_req),
        .trap_req_i          (trap_req),
        .irq_i               (irq),
        .rdata_o             (rdata),
        .interrupt_pending_o (pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc),
        .mtvec_o             (mtvec)
    );

    bind csr_bank csr_bank_properties i_csr_bank_properties (
        .clk         (clk),
        .reset_n     (reset_n),
        .csr_req_i   (csr_req_i),
        .trap_req_i  (trap_req_i),
        .rdata_i     (rdata_o),
        .pending_i   (interrupt_pending_o),
        .privilege_i (privilege_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Table entry builders
    ////////////////////////////////////////

    function automatic void store_step(input string name, input step_t s);
        steps.push_back(s);
        names.push_back(name);
    endfunction

    function automatic step_t csr_access(input logic rd, input logic wr, input csr_op_e op,
                                         input csr_addr_t addr, input logic [XLEN-1:0] data,
                                         input logic [XLEN-1:0] expected);
        step_t s;
        s           = '0;
        s.act       = ACT_CSR;
        s.req.read  = rd;
        s.req.write = wr;
        s.req.op    = op;
        s.req.addr  = addr;
        s.req.data  = data;
        s.target    = rd ? CHK_RDATA : CHK_NONE;
        s.expected  = expected;
        return s;
    endfunction

    function automatic step_t idle_cycles(input int cycles, input target_e target,
                                          input logic [XLEN-1:0] expected);
        step_t s;
        s          = '0;
        s.act      = ACT_IDLE;
        s.cycles   = cycles;
        s.target   = target;
        s.expected = expected;
        return s;
    endfunction

    function automatic step_t trap_event(input trap_req_t t);
        step_t s;
        s      = '0;
        s.act  = ACT_TRAP;
        s.trap = t;
        return s;
    endfunction

    function automatic step_t irq_change(input logic [XLEN-1:0] level);
        step_t s;
        s     = '0;
        s.act = ACT_IRQ;
        s.irq = level;
        return s;
    endfunction

    function automatic step_t pending_wait(input int timeout);
        step_t s;
        s        = '0;
        s.act    = ACT_WAIT;
        s.cycles = timeout;
        return s;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    function automatic void build_table();
        logic [XLEN-1:0] r1, r2, r3, r4, p1, p2, p3, p4, i1, tgt, w, v;
        trap_req_t       t;
        step_t           s;
        r1  = $random(seed);
        r2  = $random(seed);
        r3  = $random(seed);
        r4  = $random(seed);
        p1  = $random(seed) & 32'hFFFF_FFFC;
        p2  = $random(seed) & 32'hFFFF_FFFC;
        p3  = $random(seed) & 32'hFFFF_FFFC;
        p4  = $random(seed) & 32'hFFFF_FFFC;
        i1  = $random(seed);
        tgt = $random(seed) & 32'hFFFF_FFFC;
        w   = $random(seed) & 32'h0FFF_FFFF;   // No carry into mcycleh
        v   = $random(seed) & 32'h0FFF_FFFF;

        // Write, set and clear under the masks
        store_step("mscratch write", csr_access(1'b0, 1'b1, CSR_WRITE, MSCRATCH, r1, '0));
        store_step("mscratch read", csr_access(1'b1, 1'b0, CSR_WRITE, MSCRATCH, '0, r1));
        store_step("mscratch set", csr_access(1'b0, 1'b1, CSR_SET, MSCRATCH, r2, '0));
        store_step("mscratch after set", csr_access(1'b1, 1'b0, CSR_WRITE, MSCRATCH, '0, r1 | r2));
        store_step("mscratch clear", csr_access(1'b0, 1'b1, CSR_CLEAR, MSCRATCH, r3, '0));
        store_step("mscratch after clear",
                   csr_access(1'b1, 1'b0, CSR_WRITE, MSCRATCH, '0, (r1 | r2) & ~r3));
        store_step("mtvec write", csr_access(1'b0, 1'b1, CSR_WRITE, MTVEC, r4, '0));
        store_step("mtvec output", idle_cycles(1, CHK_MTVEC, r4 & 32'hFFFF_FFFC));
        store_step("mtvec set low bits", csr_access(1'b0, 1'b1, CSR_SET, MTVEC, 32'h3, '0));
        store_step("mtvec read", csr_access(1'b1, 1'b0, CSR_WRITE, MTVEC, '0, r4 & 32'hFFFF_FFFC));
        store_step("mie write ones", csr_access(1'b0, 1'b1, CSR_WRITE, MIE, '1, '0));
        store_step("mie read", csr_access(1'b1, 1'b0, CSR_WRITE, MIE, '0, 32'h888));
        store_step("mie clear msie", csr_access(1'b0, 1'b1, CSR_CLEAR, MIE, 32'h8, '0));
        store_step("mie after clear", csr_access(1'b1, 1'b0, CSR_WRITE, MIE, '0, 32'h880));

        // Killed requests, misa, empty and unknown reads
        s = csr_access(1'b1, 1'b1, CSR_WRITE, MSCRATCH, ~r1, '0);
        s.req.killed = 1'b1;
        store_step("killed access", s);
        store_step("mscratch kept",
                   csr_access(1'b1, 1'b0, CSR_WRITE, MSCRATCH, '0, (r1 | r2) & ~r3));
        store_step("misa read", csr_access(1'b1, 1'b0, CSR_WRITE, MISA, '0, MISA_VALUE));
        s = csr_access(1'b0, 1'b0, CSR_WRITE, MSCRATCH, '0, '0);
        s.target = CHK_RDATA;
        store_step("no read request", s);
        store_step("unknown address",
                   csr_access(1'b1, 1'b0, CSR_WRITE, csr_addr_t'(12'h7C0), '0, '0));
        store_step("mvendorid read", csr_access(1'b1, 1'b0, CSR_WRITE, MVENDORID, '0, '0));

        // Exceptions taken from machine mode
        store_step("mstatus set mie", csr_access(1'b0, 1'b1, CSR_WRITE, MSTATUS, 32'h8, '0));
        t = '0;
        t.raise_exception = 1'b1;
        t.exception_code  = ILLEGAL_INSTRUCTION;
        t.pc              = p1;
        t.instruction     = i1;
        store_step("illegal instruction", trap_event(t));
        store_step("illegal mepc", idle_cycles(1, CHK_MEPC, p1));
        store_step("illegal mtval", csr_access(1'b1, 1'b0, CSR_WRITE, MTVAL, '0, i1));
        store_step("illegal mcause", csr_access(1'b1, 1'b0, CSR_WRITE, MCAUSE, '0, 32'd2));
        store_step("illegal mstatus", csr_access(1'b1, 1'b0, CSR_WRITE, MSTATUS, '0, 32'h1880));
        store_step("illegal privilege", idle_cycles(1, CHK_PRIV, 32'd3));
        t.exception_code  = ECALL_M;
        t.pc              = p2;
        store_step("ecall", trap_event(t));
        store_step("ecall mepc", idle_cycles(1, CHK_MEPC, p2));
        store_step("ecall mtval", csr_access(1'b1, 1'b0, CSR_WRITE, MTVAL, '0, p2));
        store_step("ecall mcause", csr_access(1'b1, 1'b0, CSR_WRITE, MCAUSE, '0, 32'd11));

        // Return to user mode
        store_step("mstatus mpp user", csr_access(1'b0, 1'b1, CSR_WRITE, MSTATUS, 32'h80, '0));
        t = '0;
        t.machine_return = 1'b1;
        store_step("mret to user", trap_event(t));
        store_step("mret privilege", idle_cycles(1, CHK_PRIV, 32'd0));
        store_step("mret mstatus", csr_access(1'b1, 1'b0, CSR_WRITE, MSTATUS, '0, 32'h88));

        // External wins over timer when both are raised
        store_step("raise timer and ext", irq_change(32'h0000_0880));
        store_step("wait pending", pending_wait(20));
        t = '0;
        t.interrupt_ack = 1'b1;
        t.pc            = p3;
        store_step("ack at pc", trap_event(t));
        store_step("pending low after ack", idle_cycles(1, CHK_PEND, 32'd0));
        store_step("ack mepc", idle_cycles(1, CHK_MEPC, p3 + 32'd4));
        store_step("ack mcause", csr_access(1'b1, 1'b0, CSR_WRITE, MCAUSE, '0, 32'h8000_000B));
        store_step("ack mstatus", csr_access(1'b1, 1'b0, CSR_WRITE, MSTATUS, '0, 32'h80));
        t = '0;
        t.machine_return = 1'b1;
        store_step("mret reenable", trap_event(t));
        store_step("wait pending again", pending_wait(20));
        t = '0;
        t.interrupt_ack = 1'b1;
        t.pc            = p4;
        t.jump          = 1'b1;
        t.jump_target   = tgt;
        store_step("ack on jump", trap_event(t));
        store_step("jump mepc", idle_cycles(1, CHK_MEPC, tgt));
        store_step("drop irq lines", irq_change('0));

        // Counters
        store_step("mcycle write", csr_access(1'b0, 1'b1, CSR_WRITE, MCYCLE, w, '0));
        store_step("idle five", idle_cycles(5, CHK_NONE, '0));
        store_step("mcycle read", csr_access(1'b1, 1'b0, CSR_WRITE, MCYCLE, '0, w + 32'd5));
        store_step("cycle alias", csr_access(1'b1, 1'b0, CSR_WRITE, CYCLE, '0, w + 32'd6));
        store_step("mcycleh read", csr_access(1'b1, 1'b0, CSR_WRITE, MCYCLEH, '0, '0));
        store_step("minstret write", csr_access(1'b0, 1'b1, CSR_WRITE, MINSTRET, v, '0));
        s = idle_cycles(4, CHK_NONE, '0);
        s.req.killed = 1'b1;
        store_step("killed cycles", s);
        store_step("minstret held", csr_access(1'b1, 1'b0, CSR_WRITE, MINSTRET, '0, v));
        store_step("instret alias", csr_access(1'b1, 1'b0, CSR_WRITE, INSTRET, '0, v + 32'd1));
    endfunction

    ////////////////////////////////////////
    // Driving and checking
    ////////////////////////////////////////

    // Drive on the rising edge, sample at the falling edge
    task automatic apply_inputs(input step_t s);
        @(posedge clk);
        csr_req  <= s.req;
        trap_req <= s.trap;
        irq      <= irq_level;
        @(negedge clk);
    endtask

    function automatic logic [XLEN-1:0] observed(input target_e target);
        case (target)
            CHK_RDATA: return rdata;
            CHK_MEPC:  return mepc;
            CHK_MTVEC: return mtvec;
            CHK_PRIV:  return {30'd0, privilege};
            CHK_PEND:  return {31'd0, pending};
            default:   return '0;
        endcase
    endfunction

    task automatic run_step(input int idx);
        step_t           s;
        logic [XLEN-1:0] actual;
        logic            ok;
        int              n;
        s  = steps[idx];
        ok = 1'b1;
        if (s.act == ACT_IRQ) begin
            irq_level = s.irq;
        end
        if (s.act == ACT_WAIT) begin
            n = 0;
            while (n < s.cycles && !pending) begin
                apply_inputs(s);
                n++;
            end
            assert (pending) else begin
                $display("Timeout in %s: no interrupt pending after %0d cycles", names[idx], n);
                ok = 1'b0;
            end
        end
        else begin
            n = (s.act == ACT_IDLE) ? s.cycles : 1;
            repeat (n) apply_inputs(s);
            if (s.target != CHK_NONE) begin
                actual = observed(s.target);
                assert (actual === s.expected) else begin
                    $display("[ERROR] %s: expected %h, actual %h", names[idx], s.expected, actual);
                    ok = 1'b0;
                end
            end
        end
        if (ok) begin
            passed++;
        end
        else begin
            failed++;
        end
        $display("Test %0d %s: %s", idx, names[idx], ok ? "ok" : "failed");
    endtask

    initial begin
        int idx;
        seed      = 31;
        passed    = 0;
        failed    = 0;
        irq_level = '0;
        reset_n   = 1'b0;
        csr_req   = '0;
        trap_req  = '0;
        irq       = '0;
        build_table();
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        for (idx = 0; idx < steps.size(); idx++) begin
            run_step(idx);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", steps.size(), passed, failed);
        if (failed == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
source/csr_pkg.sv
source/trap_pkg.sv
source/csr_access.sv
source/csr_machine_regs.sv
source/csr_counters.sv
source/irq_control.sv
source/csr_bank.sv
tb/csr_bank_properties.sv
tb/csr_bank_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module csr_bank_tb -f src.f -Mdir obj_dir \
    && ./obj_dir/Vcsr_bank_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
